//--- design/noc_macros.svh
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// mesh dimensions, nodes per row and per column
`define NOC_X_NODES    4
`define NOC_Y_NODES    4

// bits per coordinate, enough for 4 nodes
`define NOC_COORD_W    2

// payload bits carried in each flit
`define NOC_PAYLOAD_W  4

// entries in each input FIFO
`define NOC_FIFO_DEPTH 2

// local, east, north, west, south
`define NOC_PORTS      5

`endif

//--- design/noc_pkg.sv
`default_nettype none

`include "noc_macros.svh"

package noc_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // port codes
   ////////////////////////////////////////////////////////////////////////////

   // code 0 means no route
   // array index is always code minus one
   typedef enum logic [2:0] {
      PORT_NONE  = 3'd0,
      PORT_LOCAL = 3'd1,
      PORT_EAST  = 3'd2,
      PORT_NORTH = 3'd3,
      PORT_WEST  = 3'd4,
      PORT_SOUTH = 3'd5
   } port_e;

   // one bit per port index
   // bit 0 local ... bit 4 south
   typedef logic [`NOC_PORTS-1:0] port_mask_t;

   ////////////////////////////////////////////////////////////////////////////
   // flit layout
   ////////////////////////////////////////////////////////////////////////////

   // single flit packet, 8 bits in total
   // destination sits in the upper nibble, x above y
   typedef struct packed {
      // column, grows eastward
      logic [`NOC_COORD_W-1:0]   dest_x;
      // row, grows southward
      logic [`NOC_COORD_W-1:0]   dest_y;
      // opaque data, passed through untouched
      logic [`NOC_PAYLOAD_W-1:0] payload;
   } flit_t;

endpackage

`default_nettype wire

//--- design/route_if.sv
`default_nettype none

// head flit of one input, with its routing request
// one instance per input port
interface route_if;
   import noc_pkg::*;

   // fifo not empty
   logic       valid;
   // current head entry
   flit_t      flit;
   // one-hot output wanted by the head
   port_mask_t request;
   // head consumed by an arbiter
   logic       pop;

   // input port side
   modport source (
      output valid,
      output flit,
      output request,
      input  pop
   );

   // arbiter side, read only
   modport sink (
      input valid,
      input flit,
      input request
   );

endinterface

`default_nettype wire

//--- design/xy_route_compute.sv
`default_nettype none

`include "noc_macros.svh"

// dimension ordered routing, x resolved first, then y
module xy_route_compute #(
   parameter int NODE_X = 1,
   parameter int NODE_Y = 1
) (
   input  wire logic [`NOC_COORD_W-1:0] dest_x,
   input  wire logic [`NOC_COORD_W-1:0] dest_y,
   output noc_pkg::port_e               port,
   output noc_pkg::port_mask_t          request
);
   import noc_pkg::*;

   // one extra bit so the difference keeps its sign
   localparam logic signed [`NOC_COORD_W:0] POS_X = (`NOC_COORD_W+1)'(NODE_X);
   localparam logic signed [`NOC_COORD_W:0] POS_Y = (`NOC_COORD_W+1)'(NODE_Y);

   logic signed [`NOC_COORD_W:0] xdiff;
   logic signed [`NOC_COORD_W:0] ydiff;

   // destination minus own position
   assign xdiff = $signed({1'b0, dest_x}) - POS_X;
   assign ydiff = $signed({1'b0, dest_y}) - POS_Y;

   ////////////////////////////////////////////////////////////////////////////
   // port decision
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      if (xdiff > 0) begin
         port = PORT_EAST;
      end else if (xdiff < 0) begin
         port = PORT_WEST;
      end else if (ydiff > 0) begin
         // y grows southward
         port = PORT_SOUTH;
      end else if (ydiff < 0) begin
         port = PORT_NORTH;
      end else begin
         // arrived
         port = PORT_LOCAL;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // code to one-hot, bit index is code minus one
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      request = '0;
      case (port)
         PORT_LOCAL: request[0] = 1'b1;
         PORT_EAST:  request[1] = 1'b1;
         PORT_NORTH: request[2] = 1'b1;
         PORT_WEST:  request[3] = 1'b1;
         PORT_SOUTH: request[4] = 1'b1;
         default:    request    = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- design/input_port.sv
`default_nettype none

`include "noc_macros.svh"

// four-phase receiver feeding a small flit fifo
// head entry is routed and offered to the arbiters
module input_port #(
   parameter int NODE_X = 1,
   parameter int NODE_Y = 1
) (
   input  wire logic           clk,
   input  wire logic           rst_n,
   input  wire logic           req,
   output logic                ack,
   input  wire noc_pkg::flit_t flit_in,
   route_if.source             head
);
   import noc_pkg::*;

   localparam int DEPTH = `NOC_FIFO_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   typedef enum logic {
      RX_IDLE,
      RX_ACK
   } rx_state_e;

   rx_state_e        rx_state;
   flit_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             push;
   logic             pop;
   port_mask_t       route_req;

   // circular pointer step
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // four-phase receiver
   ////////////////////////////////////////////////////////////////////////////

   assign full = (count == CNT_W'(DEPTH));

   // store only while ack is low and there is room
   assign push = (rx_state == RX_IDLE) && req && !full;
   assign ack  = (rx_state == RX_ACK);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_state <= RX_IDLE;
      end else begin
         case (rx_state)
            RX_IDLE: if (push) rx_state <= RX_ACK;
            // wait for the sender to drop req
            RX_ACK:  if (!req) rx_state <= RX_IDLE;
            default: rx_state <= RX_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // flit fifo
   ////////////////////////////////////////////////////////////////////////////

   // arbiters only grant a valid head
   assign pop = head.pop;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= next_ptr(wr_ptr);
         if (pop)  rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // storage
   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= flit_in;
   end

   ////////////////////////////////////////////////////////////////////////////
   // head routing
   ////////////////////////////////////////////////////////////////////////////

   xy_route_compute #(
      .NODE_X (NODE_X),
      .NODE_Y (NODE_Y)
   ) i_xy_route_compute (
      .dest_x  (mem[rd_ptr].dest_x),
      .dest_y  (mem[rd_ptr].dest_y),
      .port    (),
      .request (route_req)
   );

   assign head.valid   = (count != '0);
   assign head.flit    = mem[rd_ptr];
   assign head.request = route_req;

endmodule

`default_nettype wire

//--- design/output_arbiter.sv
`default_nettype none

`include "noc_macros.svh"

// round-robin pick among the inputs, then a four-phase send
module output_arbiter (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire noc_pkg::port_mask_t requests,
   input  wire noc_pkg::flit_t      flits [`NOC_PORTS],
   output noc_pkg::port_mask_t      grant,
   output logic                     req,
   input  wire logic                ack,
   output noc_pkg::flit_t           flit_out
);
   import noc_pkg::*;

   localparam int NP    = `NOC_PORTS;
   localparam int IDX_W = $clog2(NP);

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_REQ,
      TX_WAIT_LOW
   } tx_state_e;

   tx_state_e        tx_state;
   logic [IDX_W-1:0] rr_ptr;
   logic [IDX_W-1:0] winner;
   logic             found;
   logic             take;
   flit_t            hold;

   ////////////////////////////////////////////////////////////////////////////
   // rotating priority search
   ////////////////////////////////////////////////////////////////////////////

   // first requester at or after the pointer
   always_comb begin
      int idx;
      found  = 1'b0;
      winner = '0;
      for (int k = 0; k < NP; k++) begin
         idx = (int'(rr_ptr) + k) % NP;
         if (!found && requests[idx]) begin
            found  = 1'b1;
            winner = IDX_W'(idx);
         end
      end
   end

   // grant only when the sender is free
   assign take = (tx_state == TX_IDLE) && found;

   always_comb begin
      grant = '0;
      if (take) begin
         grant[winner] = 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // sender fsm and pointer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_state <= TX_IDLE;
         rr_ptr   <= '0;
      end else begin
         case (tx_state)
            TX_IDLE: begin
               if (take) begin
                  tx_state <= TX_REQ;
                  // one past the winner, wrapping at the last port
                  if (winner == IDX_W'(NP - 1)) begin
                     rr_ptr <= '0;
                  end else begin
                     rr_ptr <= winner + 1'b1;
                  end
               end
            end
            // req high until the receiver acks
            TX_REQ: begin
               if (ack) tx_state <= TX_WAIT_LOW;
            end
            // req low, receiver must release ack
            TX_WAIT_LOW: begin
               if (!ack) tx_state <= TX_IDLE;
            end
            default: tx_state <= TX_IDLE;
         endcase
      end
   end

   // holding register, loaded with the grant
   always_ff @(posedge clk) begin
      if (take) hold <= flits[winner];
   end

   assign req      = (tx_state == TX_REQ);
   assign flit_out = hold;

endmodule

`default_nettype wire

//--- design/mesh_router.sv
`default_nettype none

`include "noc_macros.svh"

// five-port router, one node of the 4x4 mesh
// index order local, east, north, west, south
module mesh_router #(
   parameter int NODE_X = 1,
   parameter int NODE_Y = 1
) (
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire logic [`NOC_PORTS-1:0] in_req,
   output logic [`NOC_PORTS-1:0]      in_ack,
   input  wire noc_pkg::flit_t        in_flit [`NOC_PORTS],
   output logic [`NOC_PORTS-1:0]      out_req,
   input  wire logic [`NOC_PORTS-1:0] out_ack,
   output noc_pkg::flit_t             out_flit [`NOC_PORTS]
);
   import noc_pkg::*;

   localparam int NP = `NOC_PORTS;

   // first index is the output, second the input
   logic [NP-1:0][NP-1:0] req_by_out;
   logic [NP-1:0][NP-1:0] grant_by_out;
   // first index is the input, second the output
   logic [NP-1:0][NP-1:0] grant_by_in;
   flit_t                 head_flits [NP];

   route_if heads [NP] ();

   ////////////////////////////////////////////////////////////////////////////
   // input side
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < NP; i++) begin : g_in
      input_port #(
         .NODE_X (NODE_X),
         .NODE_Y (NODE_Y)
      ) i_input_port (
         .clk     (clk),
         .rst_n   (rst_n),
         .req     (in_req[i]),
         .ack     (in_ack[i]),
         .flit_in (in_flit[i]),
         .head    (heads[i])
      );

      assign head_flits[i] = heads[i].flit;

      // regroup by output, masked with head valid
      for (genvar o = 0; o < NP; o++) begin : g_xpose
         assign req_by_out[o][i]  = heads[i].valid & heads[i].request[o];
         assign grant_by_in[i][o] = grant_by_out[o][i];
      end

      // request is one-hot, so at most one grant lands here
      assign heads[i].pop = |grant_by_in[i];
   end

   ////////////////////////////////////////////////////////////////////////////
   // output side
   ////////////////////////////////////////////////////////////////////////////

   for (genvar o = 0; o < NP; o++) begin : g_out
      output_arbiter i_output_arbiter (
         .clk      (clk),
         .rst_n    (rst_n),
         .requests (req_by_out[o]),
         .flits    (head_flits),
         .grant    (grant_by_out[o]),
         .req      (out_req[o]),
         .ack      (out_ack[o]),
         .flit_out (out_flit[o])
      );
   end

endmodule

`default_nettype wire

//--- tests/mesh_router_tb.sv
`default_nettype none

`include "noc_macros.svh"

module mesh_router_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import noc_pkg::*;

   localparam int NP     = `NOC_PORTS;
   localparam int CW     = `NOC_COORD_W;
   localparam int PW     = `NOC_PAYLOAD_W;
   localparam int DEPTH  = `NOC_FIFO_DEPTH;
   localparam int NODE_X = 1;
   localparam int NODE_Y = 1;
   // backpressure test, fifo plus holding register, one stalled, two after release
   localparam int N_BP     = DEPTH + 4;
   localparam int N_FLITS  = 16 + 8 + 2 * NP + N_BP + 200;
   localparam int WATCHDOG = N_FLITS * 40 + 2000;

   logic          clk = 1'b0;
   logic          rst_n;
   logic [NP-1:0] in_req;
   logic [NP-1:0] in_ack;
   flit_t         in_flit [NP];
   logic [NP-1:0] out_req;
   logic [NP-1:0] out_ack = '0;
   flit_t         out_flit [NP];
   // receiver holds off its ack while set
   logic [NP-1:0] stall = '0;

   // arrivals per output
   flit_t rx_q [NP][$];
   // expected flits, index is input * NP + output
   flit_t exp_q [NP*NP][$];
   // random traffic waiting to be sent, per input
   flit_t plan_q [NP][$];

   int          sent_count = 0;
   int          recv_count = 0;
   int          flit_errs  = 0;
   int          port_errs  = 0;
   int          level_errs = 0;
   int          other_errs = 0;
   logic [31:0] rng_state  = 32'd42600;

   mesh_router #(
      .NODE_X (NODE_X),
      .NODE_Y (NODE_Y)
   ) i_mesh_router (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_req   (in_req),
      .in_ack   (in_ack),
      .in_flit  (in_flit),
      .out_req  (out_req),
      .out_ack  (out_ack),
      .out_flit (out_flit)
   );

   always #10 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // output receivers, four-phase
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      for (int o = 0; o < NP; o++) begin
         if (!rst_n) begin
            out_ack[o] <= 1'b0;
         end else if (out_req[o] && !out_ack[o] && !stall[o]) begin
            out_ack[o] <= 1'b1;
            rx_q[o].push_back(out_flit[o]);
            recv_count++;
         end else if (!out_req[o]) begin
            // release once req has dropped
            out_ack[o] <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference model and helpers
   ////////////////////////////////////////////////////////////////////////////

   // x first, then y, y grows southward
   function automatic port_e expected_port(input flit_t f);
      if (int'(f.dest_x) > NODE_X) return PORT_EAST;
      if (int'(f.dest_x) < NODE_X) return PORT_WEST;
      if (int'(f.dest_y) > NODE_Y) return PORT_SOUTH;
      if (int'(f.dest_y) < NODE_Y) return PORT_NORTH;
      return PORT_LOCAL;
   endfunction

   function automatic flit_t make_flit(input int x, input int y, input int p);
      flit_t f;
      f.dest_x  = CW'(x);
      f.dest_y  = CW'(y);
      f.payload = PW'(p);
      return f;
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_flit(input flit_t got, input flit_t exp, input int o);
      if (got !== exp) begin
         $display("ERR %0t output %0d flit %h, expected %h", $time, o, got, exp);
         flit_errs++;
      end
   endtask

   task automatic check_port(input port_e got, input port_e exp, input flit_t f);
      if (got !== exp) begin
         $display("ERR %0t flit %h left on port %0d, expected port %0d",
                  $time, f, got, exp);
         port_errs++;
      end
   endtask

   task automatic check_level(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("ERR %0t %s is %b, expected %b", $time, what, got, exp);
         level_errs++;
      end
   endtask

   // one four-phase transfer on input i
   task automatic send_flit(input int i, input flit_t f);
      exp_q[i*NP + int'(expected_port(f)) - 1].push_back(f);
      sent_count++;
      @(posedge clk);
      in_req[i]  <= 1'b1;
      in_flit[i] <= f;
      do @(posedge clk); while (!in_ack[i]);
      in_req[i] <= 1'b0;
      do @(posedge clk); while (in_ack[i]);
   endtask

   task automatic send_list(input int i);
      flit_t f;
      while (plan_q[i].size() > 0) begin
         f = plan_q[i].pop_front();
         send_flit(i, f);
      end
   endtask

   // the watchdog covers a flit that never shows up
   task automatic wait_all();
      while (recv_count < sent_count) @(posedge clk);
      // quiet period, catches duplicates
      repeat (20) @(posedge clk);
      if (recv_count != sent_count) begin
         $display("received %0d flits but only %0d were sent", recv_count, sent_count);
         other_errs++;
      end
   endtask

   // match each arrival to the oldest pending flit of some input
   task automatic score_outputs();
      flit_t got;
      int    hit;
      int    first;
      for (int o = 0; o < NP; o++) begin
         while (rx_q[o].size() > 0) begin
            got = rx_q[o].pop_front();
            check_port(port_e'(3'(o + 1)), expected_port(got), got);
            hit   = -1;
            first = -1;
            for (int i = 0; i < NP; i++) begin
               if (first < 0 && exp_q[i*NP+o].size() > 0) first = i;
               if (hit < 0 && exp_q[i*NP+o].size() > 0 && exp_q[i*NP+o][0] == got) hit = i;
            end
            if (hit >= 0) begin
               exp_q[hit*NP+o].delete(0);
            end else if (first >= 0) begin
               check_flit(got, exp_q[first*NP+o][0], o);
            end else begin
               $display("flit %h arrived on output %0d with nothing pending there", got, o);
               other_errs++;
            end
         end
      end
      for (int q = 0; q < NP*NP; q++) begin
         if (exp_q[q].size() > 0) begin
            $display("%0d flits from input %0d never arrived on output %0d",
                     exp_q[q].size(), q / NP, q % NP);
            other_errs++;
            exp_q[q].delete();
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic reset_levels_low();
      @(posedge clk);
      for (int o = 0; o < NP; o++) begin
         check_level(in_ack[o], 1'b0, "in_ack after reset");
         check_level(out_req[o], 1'b0, "out_req after reset");
      end
   endtask

   // local input, every node of the mesh
   task automatic route_every_destination();
      for (int x = 0; x < `NOC_X_NODES; x++) begin
         for (int y = 0; y < `NOC_Y_NODES; y++) begin
            send_flit(0, make_flit(x, y, x * `NOC_Y_NODES + y));
         end
      end
      wait_all();
      score_outputs();
   endtask

   // north input to south output
   task automatic keep_order_north_south();
      for (int k = 0; k < 8; k++) begin
         send_flit(2, make_flit(NODE_X, 3, k));
      end
      wait_all();
      score_outputs();
   endtask

   // all inputs at once to local, two flits each
   // payload low bits are the input index, bit 3 the sequence
   task automatic share_local_output();
      logic [NP-1:0] seen;
      flit_t         f;
      int            src;
      for (int i = 0; i < NP; i++) begin
         plan_q[i].push_back(make_flit(NODE_X, NODE_Y, i));
         plan_q[i].push_back(make_flit(NODE_X, NODE_Y, 8 + i));
      end
      fork
         send_list(0);
         send_list(1);
         send_list(2);
         send_list(3);
         send_list(4);
      join
      wait_all();
      seen = '0;
      if (rx_q[0].size() != 2 * NP) begin
         $display("local output got %0d flits in the fairness test, not %0d",
                  rx_q[0].size(), 2 * NP);
         other_errs++;
      end
      for (int k = 0; k < rx_q[0].size(); k++) begin
         f   = rx_q[0][k];
         src = int'(f.payload) % 8;
         // a new pass starts every NP arrivals
         if (k % NP == 0) seen = '0;
         if (src >= NP || seen[src]) begin
            $display("input %0d served twice in one round-robin pass", src);
            other_errs++;
         end else begin
            seen[src] = 1'b1;
         end
      end
      score_outputs();
   endtask

   // east stalled, fifo plus holding register fill, then the input blocks
   task automatic block_on_stalled_east();
      @(posedge clk);
      stall[1] <= 1'b1;
      for (int k = 0; k <= DEPTH; k++) begin
         send_flit(0, make_flit(2 + k % 2, k % 4, k));
      end
      fork
         send_flit(0, make_flit(3, 0, DEPTH + 1));
         begin
            // req goes up on this edge
            @(posedge clk);
            repeat (50) begin
               @(posedge clk);
               check_level(in_ack[0], 1'b0, "in_ack of the stalled input");
            end
            stall[1] <= 1'b0;
         end
      join
      for (int k = DEPTH + 2; k < N_BP; k++) begin
         send_flit(0, make_flit(2, 3, k));
      end
      wait_all();
      score_outputs();
   endtask

   // payload carries the source input, so flits of different inputs never look alike
   task automatic run_random_traffic();
      logic [31:0] r;
      int          src;
      for (int n = 0; n < 200; n++) begin
         r         = xorshift32(rng_state);
         rng_state = r;
         src       = int'(r % 32'd5);
         plan_q[src].push_back(make_flit(int'(r[9:8]), int'(r[11:10]),
                                         src * 2 + int'(r[12])));
      end
      fork
         send_list(0);
         send_list(1);
         send_list(2);
         send_list(3);
         send_list(4);
      join
      wait_all();
      score_outputs();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence and watchdog
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      rst_n  = 1'b0;
      in_req = '0;
      for (int i = 0; i < NP; i++) begin
         in_flit[i] = '0;
      end
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      reset_levels_low();
      route_every_destination();
      keep_order_north_south();
      share_local_output();
      block_on_stalled_east();
      run_random_traffic();
      $display("errors: flit %0d, port %0d, level %0d, other %0d",
               flit_errs, port_errs, level_errs, other_errs);
      if (flit_errs + port_errs + level_errs + other_errs == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG) @(posedge clk);
      $display("watchdog expired after %0d cycles with flits still in flight", WATCHDOG);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
design/noc_pkg.sv
design/route_if.sv
design/xy_route_compute.sv
design/input_port.sv
design/output_arbiter.sv
design/mesh_router.sv
tests/mesh_router_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the router testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module mesh_router_tb \
   -f sources.f -o mesh_router_sim &&
./obj_dir/mesh_router_sim | tee /dev/stderr | grep -q "^STATUS: PASS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
